// ==== logic/sportPkg.sv ====
`default_nettype none

package sportPkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Data path widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int DataWidth = 16;  // Hold word and core write data
  localparam int SlenWidth = 4;   // Code n gives n+1 bits per word
  localparam int CodeWidth = 8;   // One G.711 mu-law code

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Transmit FSM encoding
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // One-hot, so each state is a single flop in the register
  typedef enum logic [2:0] {
    TxIdle      = 3'b001,  // Waiting for a frame sync
    TxShift     = 3'b010,  // Shifting the current word
    TxWordStart = 3'b100   // First bit of a following word
  } txStateT;

endpackage

`default_nettype wire

// ==== logic/muLawCompressor.sv ====
`timescale 1ns/1ps
`default_nettype none

module muLawCompressor (
  input  logic [sportPkg::DataWidth-1:0] linear,
  output logic [sportPkg::CodeWidth-1:0] code
);

  localparam int MagWidth = 14;
  localparam logic [MagWidth-1:0] ClipLevel = 14'd8158;
  localparam logic [MagWidth-1:0] Bias = 14'd33;

  logic [MagWidth-1:0] sample;
  logic                sign;
  logic [MagWidth-1:0] magnitude;
  logic [MagWidth-1:0] clipped;
  logic [MagWidth-1:0] biased;
  logic [MagWidth-1:0] scaled;
  logic [2:0]          segment;
  logic [3:0]          mantissa;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sign and magnitude
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign sample    = linear[sportPkg::DataWidth-1 -: MagWidth];  // Drop the two LSBs
  assign sign      = sample[MagWidth-1];
  assign magnitude = sign ? (~sample + 1'b1) : sample;  // Full negative gives 8192

  // Clip keeps the biased value inside 13 bits
  assign clipped = (magnitude > ClipLevel) ? ClipLevel : magnitude;
  assign biased  = clipped + Bias;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Segment and mantissa
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // The bias guarantees bit 5 or above is set, so segment 0 covers up to bit 5
  always_comb begin
    segment = '0;
    for (int i = 6; i < 13; i++) begin
      if (biased[i]) begin
        segment = 3'(i - 5);  // Highest set bit wins
      end
    end
  end

  assign scaled   = (biased >> 1) >> segment;  // Four bits below the leading one
  assign mantissa = scaled[3:0];

  // G.711 sends every bit inverted
  assign code = ~{sign, segment, mantissa};

endmodule

`default_nettype wire

// ==== logic/txHoldReg.sv ====
`timescale 1ns/1ps
`default_nettype none

module txHoldReg (
  input  logic                           SCLKg5,
  input  logic                           rst_SP_ENg,
  input  logic                           wrEn,
  input  logic [sportPkg::DataWidth-1:0] wrData,
  input  logic                           compEn,
  input  logic                           take,
  output logic [sportPkg::DataWidth-1:0] holdWord,
  output logic                           txReq
);

  localparam int ExtWidth = sportPkg::DataWidth - sportPkg::CodeWidth;

  logic                           compPend;
  logic [sportPkg::CodeWidth-1:0] code;

  // Encodes whatever sits in the hold register, i.e. the word written last cycle
  muLawCompressor compressor0 (
    .linear (holdWord),
    .code   (code)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Hold register and compand reload
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge SCLKg5 or posedge rst_SP_ENg) begin
    if (rst_SP_ENg) begin
      holdWord <= '0;  // Keeps td quiet straight out of reset
      compPend <= 1'b0;
    end else begin
      compPend <= wrEn && compEn;  // Reload follows one cycle after the write
      if (wrEn) begin
        holdWord <= wrData;
      end else if (compPend) begin
        holdWord <= {{ExtWidth{code[sportPkg::CodeWidth-1]}}, code};
      end
    end
  end

  // Request stays up until the core refills the register
  always_ff @(posedge SCLKg5 or posedge rst_SP_ENg) begin
    if (rst_SP_ENg) begin
      txReq <= 1'b0;
    end else begin
      txReq <= !wrEn && (take || txReq);  // A write beats a take on the same edge
    end
  end

endmodule

`default_nettype wire

// ==== logic/txFrameCtl.sv ====
`timescale 1ns/1ps
`default_nettype none

module txFrameCtl #(
  parameter int WordCntWidth = 8
) (
  input  logic                           SCLKg5,
  input  logic                           rst_SP_ENg,
  input  logic                           frameSync,
  input  logic [sportPkg::SlenWidth-1:0] slen,
  input  logic [WordCntWidth-1:0]        mcWords,
  output logic                           take,
  output logic                           shift,
  output logic                           ist,
  output logic [3:0]                     slotNum
);

  sportPkg::txStateT state;
  sportPkg::txStateT nextState;
  sportPkg::txStateT afterBit;

  logic [sportPkg::SlenWidth-1:0] bitCnt;
  logic [sportPkg::SlenWidth-1:0] bitIdx;
  logic [WordCntWidth-1:0]        wordCnt;
  logic [WordCntWidth-1:0]        wordIdx;
  logic                           inIdle;
  logic                           frameStart;
  logic                           active;
  logic                           lastBit;
  logic                           lastWord;

  assign inIdle     = (state == sportPkg::TxIdle);
  assign frameStart = inIdle && frameSync;  // Sync is ignored once a frame runs
  assign active     = frameStart || !inIdle;

  // The sync cycle is already the first bit, so it reads the settings directly
  assign bitIdx   = inIdle ? slen : bitCnt;
  assign wordIdx  = inIdle ? mcWords : wordCnt;
  assign lastBit  = (bitIdx == '0);
  assign lastWord = (wordIdx == '0);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Next state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    if (!lastBit) begin
      afterBit = sportPkg::TxShift;
    end else if (lastWord) begin
      afterBit = sportPkg::TxIdle;
    end else begin
      afterBit = sportPkg::TxWordStart;  // Next word follows without a gap
    end
  end

  always_comb begin
    case (state)
      sportPkg::TxIdle:      nextState = frameSync ? afterBit : sportPkg::TxIdle;
      sportPkg::TxShift:     nextState = afterBit;
      sportPkg::TxWordStart: nextState = afterBit;
      default:               nextState = sportPkg::TxIdle;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // State and counters
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // bitCnt holds the index of the bit on td, wordCnt the words still to come
  always_ff @(posedge SCLKg5 or posedge rst_SP_ENg) begin
    if (rst_SP_ENg) begin
      state   <= sportPkg::TxIdle;
      bitCnt  <= '0;
      wordCnt <= '0;
    end else begin
      state <= nextState;
      if (nextState == sportPkg::TxWordStart) begin
        bitCnt  <= slen;
        wordCnt <= wordIdx - 1'b1;
      end else begin
        bitCnt  <= bitIdx - 1'b1;
        wordCnt <= wordIdx;  // Loads mcWords on the sync edge
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Strobes to the data path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign shift   = (nextState == sportPkg::TxShift);  // Stay inside the current word
  assign take    = active && (inIdle || lastBit);      // Frame start and every word end
  assign ist     = frameStart;
  assign slotNum = 4'(wordIdx);

endmodule

`default_nettype wire

// ==== logic/txShifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module txShifter (
  input  logic                           SCLKg5,
  input  logic                           rst_SP_ENg,
  input  logic [sportPkg::DataWidth-1:0] holdWord,
  input  logic                           shift,
  input  logic [sportPkg::SlenWidth-1:0] slen,
  output logic                           td
);

  logic [sportPkg::DataWidth-1:0] shiftReg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Serial shift register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Outside a word the register tracks the hold word, so the next MSB is ready
  always_ff @(posedge SCLKg5 or posedge rst_SP_ENg) begin
    if (rst_SP_ENg) begin
      shiftReg <= '0;
    end else if (shift) begin
      shiftReg <= {shiftReg[sportPkg::DataWidth-2:0], 1'b0};  // Zero fill
    end else begin
      shiftReg <= holdWord;  // Idle and last bit of every word
    end
  end

  // Word length picks the tap, so short words need no pre-alignment
  assign td = shiftReg[slen];

endmodule

`default_nettype wire

// ==== logic/sportTx.sv ====
`timescale 1ns/1ps
`default_nettype none

module sportTx #(
  parameter int WordCntWidth = 8
) (
  input  logic                           SCLKg5,
  input  logic                           rst_SP_ENg,
  input  logic                           wrEn,
  input  logic [sportPkg::DataWidth-1:0] wrData,
  input  logic                           compEn,
  input  logic                           frameSync,
  input  logic [sportPkg::SlenWidth-1:0] slen,
  input  logic [WordCntWidth-1:0]        mcWords,
  output logic                           td,
  output logic                           txReq,
  output logic                           ist,
  output logic [3:0]                     slotNum
);

  logic [sportPkg::DataWidth-1:0] holdWord;
  logic                           take;
  logic                           shift;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Core side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  txHoldReg holdReg0 (
    .SCLKg5     (SCLKg5),
    .rst_SP_ENg (rst_SP_ENg),
    .wrEn       (wrEn),
    .wrData     (wrData),
    .compEn     (compEn),
    .take       (take),
    .holdWord   (holdWord),
    .txReq      (txReq)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Serial side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  txFrameCtl #(
    .WordCntWidth (WordCntWidth)
  ) frameCtl0 (
    .SCLKg5     (SCLKg5),
    .rst_SP_ENg (rst_SP_ENg),
    .frameSync  (frameSync),
    .slen       (slen),
    .mcWords    (mcWords),
    .take       (take),
    .shift      (shift),
    .ist        (ist),
    .slotNum    (slotNum)
  );

  txShifter shifter0 (
    .SCLKg5     (SCLKg5),
    .rst_SP_ENg (rst_SP_ENg),
    .holdWord   (holdWord),
    .shift      (shift),
    .slen       (slen),
    .td         (td)
  );

endmodule

`default_nettype wire

// ==== verification/sportTxTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sportTxTb;

  localparam int WordCntWidth = 8;
  localparam int ResetCycles  = 8;
  localparam int SingleFrames = 8;
  localparam int MultiFrames  = 6;
  localparam int CompFrames   = 12;
  localparam int GapBudget    = 8;  // Idle cycles allowed around each frame
  localparam int FrameBudget  = SingleFrames * 16 + MultiFrames * 6 * 16 + 2 * 24
                                + CompFrames * 16 + 64;
  localparam int TimeoutCycles = 2 * (ResetCycles + FrameBudget
                                 + (SingleFrames + MultiFrames + CompFrames + 3) * GapBudget);

  logic                           SCLKg5;
  logic                           rst_SP_ENg;
  logic                           wrEn;
  logic [sportPkg::DataWidth-1:0] wrData;
  logic                           compEn;
  logic                           frameSync;
  logic [sportPkg::SlenWidth-1:0] slen;
  logic [WordCntWidth-1:0]        mcWords;
  logic                           td;
  logic                           txReq;
  logic                           ist;
  logic [3:0]                     slotNum;

  integer seed;
  string  testName;
  int     cycleCount;
  int     mc;
  logic   autoRefill;
  logic [sportPkg::DataWidth-1:0] compValues [CompFrames];

  // Reference model state is advanced once per cycle at the falling edge
  logic                           busy;
  int                             bitPos;
  logic [WordCntWidth-1:0]        wordsLeft;
  logic [sportPkg::DataWidth-1:0] curWord;
  logic [sportPkg::DataWidth-1:0] mHold;
  logic [sportPkg::DataWidth-1:0] prevHold;
  logic                           compPend;
  logic                           expReq;
  logic                           reqPrev;
  logic                           reqRise;

  sportTx #(
    .WordCntWidth (WordCntWidth)
  ) dut0 (
    .SCLKg5     (SCLKg5),
    .rst_SP_ENg (rst_SP_ENg),
    .wrEn       (wrEn),
    .wrData     (wrData),
    .compEn     (compEn),
    .frameSync  (frameSync),
    .slen       (slen),
    .mcWords    (mcWords),
    .td         (td),
    .txReq      (txReq),
    .ist        (ist),
    .slotNum    (slotNum)
  );

  always #2 SCLKg5 = ~SCLKg5;

  task automatic reportMismatch(input string what, input logic [31:0] expVal,
                                input logic [31:0] actVal);
    $display("[ERROR] %s: %s expected %0h actual %0h", testName, what, expVal, actVal);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // G.711 mu-law reference
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [7:0] muLawEncode(input logic [15:0] value);
    int       sample;
    int       mag;
    int       pos;
    logic     neg;
    logic [3:0] mant;
    sample = value[15:2];
    neg    = value[15];
    mag    = neg ? (16384 - sample) : sample;  // Two's complement magnitude of 14 bits
    if (mag > 8158) begin
      mag = 8158;
    end
    mag = mag + 33;
    pos = 12;
    while (pos > 5 && !mag[pos]) begin
      pos = pos - 1;
    end
    mant = 4'(mag >> (pos - 4));  // Four bits just below the leading one
    return ~{neg, 3'(pos - 5), mant};
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model and checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge SCLKg5) begin
    logic syncStart;
    logic expTd;
    logic takeNow;
    logic [7:0] code;
    if (rst_SP_ENg) begin
      assert (td === 1'b0) else reportMismatch("td in reset", 0, td);
      assert (txReq === 1'b0) else reportMismatch("txReq in reset", 0, txReq);
      assert (ist === 1'b0) else reportMismatch("ist in reset", 0, ist);
      busy     = 1'b0;
      bitPos   = 0;
      wordsLeft = '0;
      curWord  = '0;
      mHold    = '0;
      prevHold = '0;
      compPend = 1'b0;
      expReq   = 1'b0;
      reqPrev  = 1'b0;
      reqRise  = 1'b0;
    end else begin
      syncStart = !busy && frameSync;  // Sync during a frame is ignored
      if (syncStart) begin
        busy      = 1'b1;
        bitPos    = slen;
        wordsLeft = mcWords;
        curWord   = prevHold;
      end
      expTd = busy ? curWord[bitPos] : prevHold[slen];
      assert (td === expTd) else reportMismatch("td", expTd, td);
      assert (ist === syncStart) else reportMismatch("ist", syncStart, ist);
      assert (txReq === expReq) else reportMismatch("txReq", expReq, txReq);
      if (busy) begin
        assert (slotNum === wordsLeft[3:0]) else reportMismatch("slotNum", wordsLeft[3:0], slotNum);
      end
      reqRise = txReq && !reqPrev;
      reqPrev = txReq;
      takeNow = syncStart || (busy && bitPos == 0);  // Frame start and every word end
      expReq  = !wrEn && (takeNow || expReq);
      if (busy) begin
        if (bitPos != 0) begin
          bitPos = bitPos - 1;
        end else if (wordsLeft == 0) begin
          busy = 1'b0;
        end else begin
          wordsLeft = wordsLeft - 1'b1;
          bitPos    = slen;
          curWord   = mHold;  // Next word is whatever sits in the hold register now
        end
      end
      prevHold = mHold;
      code     = muLawEncode(mHold);
      if (wrEn) begin
        mHold = wrData;
      end else if (compPend) begin
        mHold = {{8{code[7]}}, code};
      end
      compPend = wrEn && compEn;
    end
  end

  writeClearsReq: assert property (@(posedge SCLKg5) disable iff (rst_SP_ENg) wrEn |=> !txReq)
    else reportMismatch("txReq after write", 0, txReq);

  istNeedsSync: assert property (@(posedge SCLKg5) disable iff (rst_SP_ENg) ist |-> frameSync)
    else abortRun("ist pulsed in a cycle without frame sync");

  // The core refills with one write in the cycle after each rise of txReq
  always @(posedge SCLKg5) begin
    if (autoRefill) begin
      wrEn <= reqRise;
      if (reqRise) begin
        wrData <= 16'($random(seed));
      end
    end
  end

  always @(posedge SCLKg5) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > TimeoutCycles) begin
      abortRun($sformatf("Timeout after %0d cycles, the run did not finish", cycleCount));
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic idleCycles(input int n);
    repeat (n) @(posedge SCLKg5);
  endtask

  task automatic writeWord(input logic [15:0] value, input logic comp);
    wrEn   <= 1'b1;
    wrData <= value;
    compEn <= comp;
    @(posedge SCLKg5);
    wrEn   <= 1'b0;
    compEn <= 1'b0;
  endtask

  // Returns at the edge that starts the first cycle after the frame
  task automatic sendFrame(input int words, input logic [3:0] len);
    frameSync <= 1'b1;
    mcWords   <= WordCntWidth'(words);
    slen      <= len;
    @(posedge SCLKg5);
    frameSync <= 1'b0;
    idleCycles((words + 1) * (len + 1) - 1);
  endtask

  initial begin
    seed       = 32'h2aaf;
    SCLKg5     = 1'b0;
    rst_SP_ENg = 1'b1;
    wrEn       = 1'b0;
    wrData     = '0;
    compEn     = 1'b0;
    frameSync  = 1'b0;
    slen       = '0;
    mcWords    = '0;
    autoRefill = 1'b0;
    cycleCount = 0;
    testName   = "reset";
    idleCycles(ResetCycles);
    rst_SP_ENg <= 1'b0;
    idleCycles(2);

    testName = "single-word frame";
    for (int i = 0; i < SingleFrames; i++) begin
      writeWord(16'($random(seed)), 1'b0);
      idleCycles(2);
      sendFrame(0, 4'($random(seed)));
      idleCycles(3);
    end

    testName = "multiword frame";
    writeWord(16'($random(seed)), 1'b0);  // Clears txReq so the first take makes it rise
    @(negedge SCLKg5);
    autoRefill = 1'b1;
    @(posedge SCLKg5);
    for (int i = 0; i < MultiFrames; i++) begin
      mc = {$random(seed)} % 6;
      sendFrame(mc, 4'($random(seed)));  // Frames run back to back so each sync checks the end
    end
    idleCycles(4);
    @(negedge SCLKg5);
    autoRefill = 1'b0;
    @(posedge SCLKg5);
    wrEn <= 1'b0;

    testName = "transmit request";
    writeWord(16'($random(seed)), 1'b0);
    idleCycles(2);
    sendFrame(2, 4'd7);  // Without a refill every word repeats and txReq stays high
    idleCycles(2);
    writeWord(16'($random(seed)), 1'b0);
    idleCycles(2);
    frameSync <= 1'b1;  // Write and take on the same edge
    mcWords   <= '0;
    slen      <= 4'd3;
    wrEn      <= 1'b1;
    wrData    <= 16'($random(seed));
    @(posedge SCLKg5);
    frameSync <= 1'b0;
    wrEn      <= 1'b0;
    idleCycles(5);

    testName      = "companding";
    compValues[0] = 16'h0000;
    compValues[1] = 16'h7fff;
    compValues[2] = 16'h8000;
    compValues[3] = 16'h7f84;  // Above the clip level
    compValues[4] = 16'h807c;
    for (int i = 5; i < CompFrames; i++) begin
      compValues[i] = 16'($random(seed));
    end
    for (int i = 0; i < CompFrames; i++) begin
      writeWord(compValues[i], 1'b1);
      idleCycles(3);
      sendFrame(0, 4'd15);
      idleCycles(2);
    end

    testName = "ignored sync";
    writeWord(16'($random(seed)), 1'b0);
    idleCycles(2);
    frameSync <= 1'b1;
    mcWords   <= WordCntWidth'(3);
    slen      <= 4'd15;
    @(posedge SCLKg5);
    frameSync <= 1'b0;
    idleCycles(19);
    frameSync <= 1'b1;  // Lands in the middle of the second word
    @(posedge SCLKg5);
    frameSync <= 1'b0;
    idleCycles(43);
    idleCycles(3);
    @(negedge SCLKg5);

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sportTx.f ====
logic/sportPkg.sv
logic/muLawCompressor.sv
logic/txHoldReg.sv
logic/txFrameCtl.sv
logic/txShifter.sv
logic/sportTx.sv
verification/sportTxTb.sv

// ==== Bender.yml ====
package:
  name: sportTx

sources:
  - files:
      - logic/sportPkg.sv
      - logic/muLawCompressor.sv
      - logic/txHoldReg.sv
      - logic/txFrameCtl.sv
      - logic/txShifter.sv
      - logic/sportTx.sv

  - target: test
    files:
      - verification/sportTxTb.sv

# Top modules: sportTx for synthesis, sportTxTb for simulation
